//--- files.f
source/link_pkg.sv
source/byte_ram.sv
source/frame_tx.sv
source/frame_rx.sv
source/link_ctrl.sv
source/link_top.sv
testbench/tb_clock.sv
testbench/link_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module link_tb -Mdir obj_dir -f files.f
./obj_dir/Vlink_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- source/byte_ram.sv
`timescale 1ns/1ps

module byte_ram import link_pkg::*; (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [LEN_W-1:0]  wr_addr,
    input  logic [BYTE_W-1:0] wr_data,
    input  logic [LEN_W-1:0]  rd_addr,
    output logic [BYTE_W-1:0] rd_data
);

    logic [BYTE_W-1:0] mem [0:(1 << LEN_W)-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // Registered read, one cycle latency
    end

endmodule

//--- source/frame_rx.sv
`timescale 1ns/1ps

module frame_rx import link_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [BYTE_W-1:0]  line_rx_data,
    input  logic               line_rx_valid,
    output logic               buf_wr_en,
    output logic [LEN_W-1:0]   buf_wr_addr,
    output logic [BYTE_W-1:0]  buf_wr_data,
    output logic               rx_done,
    output logic [BTYPE_W-1:0] rx_btype,
    output logic [LEN_W-1:0]   rx_len
);

    typedef enum logic [1:0] {
        P_HDR,
        P_LEN,
        P_DATA,
        P_SUM
    } phase_t;

    phase_t             phase;
    logic [BTYPE_W-1:0] hdr_type;
    logic               hdr_good;
    logic               hdr_ok;    // Header of the current frame was well formed
    logic [BTYPE_W-1:0] btype_q;
    logic [LEN_W-1:0]   len_q;
    logic [LEN_W-1:0]   idx;
    logic [BYTE_W-1:0]  csum;

    assign hdr_type = line_rx_data[BYTE_W-1 -: BTYPE_W];

    // Low nibble must be zero and the type one that is sent on the line
    assign hdr_good = (line_rx_data[BYTE_W-BTYPE_W-1:0] == '0) &&
                      (hdr_type inside {BAG_ACK, BAG_NAK, BAG_DPARAM, BAG_DATA0, BAG_DATA1});

    // --------------------------------------------------
    // Phase counter
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= P_HDR;
            buf_wr_en <= 1'b0;
            rx_done <= 1'b0;
        end else begin
            buf_wr_en <= 1'b0;
            rx_done <= 1'b0;
            if (line_rx_valid) begin
                case (phase)
                    P_HDR: phase <= P_LEN;
                    P_LEN: phase <= (line_rx_data == '0) ? P_SUM : P_DATA;
                    P_DATA: begin
                        buf_wr_en <= 1'b1;
                        if (idx == len_q - 1'b1) phase <= P_SUM;
                    end
                    default: begin
                        rx_done <= 1'b1;
                        phase <= P_HDR;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_rx_valid) begin
            case (phase)
                P_HDR: begin
                    btype_q <= hdr_type;
                    hdr_ok <= hdr_good;
                    csum <= line_rx_data;
                end
                P_LEN: begin
                    len_q <= line_rx_data;
                    csum <= csum ^ line_rx_data;
                    idx <= '0;
                end
                P_DATA: begin
                    buf_wr_addr <= idx;   // Payload always lands from address 0
                    buf_wr_data <= line_rx_data;
                    csum <= csum ^ line_rx_data;
                    idx <= idx + 1'b1;
                end
                default: begin
                    rx_btype <= (hdr_ok && csum == line_rx_data) ? btype_q : BAG_ERROR;
                    rx_len <= len_q;
                end
            endcase
        end
    end

endmodule

//--- source/frame_tx.sv
`timescale 1ns/1ps

module frame_tx import link_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               tx_start,
    input  logic [BTYPE_W-1:0] tx_btype,
    input  logic [LEN_W-1:0]   tx_base,
    input  logic [LEN_W-1:0]   tx_len,
    output logic [LEN_W-1:0]   buf_rd_addr,
    input  logic [BYTE_W-1:0]  buf_rd_data,
    output logic [BYTE_W-1:0]  line_tx_data,
    output logic               line_tx_valid,
    output logic               tx_done
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_HDR,
        P_LEN,
        P_DATA,
        P_SUM,
        P_FIN
    } phase_t;

    phase_t            phase;
    logic [LEN_W-1:0]  idx;   // Payload bytes already on the line
    logic [BYTE_W-1:0] csum;
    logic [BYTE_W-1:0] hdr;

    assign hdr = {tx_btype, {(BYTE_W-BTYPE_W){1'b0}}};

    // --------------------------------------------------
    // Byte sequencer
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= P_IDLE;
            line_tx_valid <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            line_tx_valid <= 1'b0;
            tx_done <= 1'b0;
            case (phase)
                P_IDLE: begin
                    if (tx_start) phase <= P_HDR;
                end
                P_HDR: begin
                    line_tx_valid <= 1'b1;
                    phase <= P_LEN;
                end
                P_LEN: begin
                    line_tx_valid <= 1'b1;
                    phase <= (tx_len == '0) ? P_SUM : P_DATA;
                end
                P_DATA: begin
                    line_tx_valid <= 1'b1;
                    if (idx == tx_len - 1'b1) phase <= P_SUM;
                end
                P_SUM: begin
                    line_tx_valid <= 1'b1;
                    phase <= P_FIN;
                end
                default: begin
                    tx_done <= 1'b1;   // Cycle after the checksum byte
                    phase <= P_IDLE;
                end
            endcase
        end
    end

    // Buffer is read one address ahead of the byte being sent
    always_ff @(posedge clk) begin
        case (phase)
            P_IDLE: buf_rd_addr <= tx_base;
            P_HDR: begin
                line_tx_data <= hdr;
                csum <= hdr;
            end
            P_LEN: begin
                line_tx_data <= tx_len;
                csum <= csum ^ tx_len;
                buf_rd_addr <= buf_rd_addr + 1'b1;
                idx <= '0;
            end
            P_DATA: begin
                line_tx_data <= buf_rd_data;
                csum <= csum ^ buf_rd_data;
                buf_rd_addr <= buf_rd_addr + 1'b1;
                idx <= idx + 1'b1;
            end
            default: line_tx_data <= csum;
        endcase
    end

endmodule

//--- source/link_ctrl.sv
`timescale 1ns/1ps

module link_ctrl import link_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // Host send request
    input  logic               send_req,
    input  logic [BTYPE_W-1:0] send_btype,
    input  logic [LEN_W-1:0]   send_len,
    input  logic [LEN_W-1:0]   send_base,
    output logic               send_done,
    output logic               send_fail,
    // Host receive report
    input  logic               read_ack,
    output logic               read_valid,
    output logic [BTYPE_W-1:0] read_btype,
    output logic [LEN_W-1:0]   read_len,
    // Frame builder
    output logic               tx_start,
    output logic [BTYPE_W-1:0] tx_btype,
    output logic [LEN_W-1:0]   tx_base,
    output logic [LEN_W-1:0]   tx_len,
    input  logic               tx_done,
    // Frame parser
    input  logic               rx_done,
    input  logic [BTYPE_W-1:0] rx_btype,
    input  logic [LEN_W-1:0]   rx_len
);

    typedef enum logic [2:0] {
        IDLE,
        SEND_PREP,
        SEND,
        ANS_WAIT,
        SEND_DONE,
        ANS_PREP,
        ANS_SEND,
        READ_PEND
    } state_t;

    state_t             state;
    logic [RETRY_W-1:0] retry_cnt;
    logic [TMR_W-1:0]   tmr;
    logic               tx_tog;    // Next data frame goes out as DATA1
    logic               rx_tog;    // DATA1 expected from the peer
    logic               ans_new;   // Frame being answered is reported afterwards
    logic               rx_data;
    logic               rx_take;
    logic               rx_fresh;
    logic               rx_nak;
    logic               tx_data;
    logic               timeout;

    assign send_done = (state == SEND_DONE);

    assign rx_data = (rx_btype == BAG_DATA0) || (rx_btype == BAG_DATA1);
    assign tx_data = (tx_btype == BAG_DATA0) || (tx_btype == BAG_DATA1);
    assign timeout = (tmr == TMR_W'(ACK_TIMEOUT - 1));

    // Incoming frame that needs an answer, stray ACK/NAK are ignored
    assign rx_take = rx_done && (state == IDLE || state == READ_PEND) &&
                     (rx_btype != BAG_ACK) && (rx_btype != BAG_NAK);

    // A data frame whose toggle does not match is a duplicate
    assign rx_fresh = !read_valid &&
                      ((rx_btype == BAG_DPARAM) ||
                       (rx_data && ((rx_btype == BAG_DATA1) == rx_tog)));
    assign rx_nak = (rx_btype == BAG_ERROR) || read_valid;

    // --------------------------------------------------
    // Main FSM
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            tx_start <= 1'b0;
            send_fail <= 1'b0;
            read_valid <= 1'b0;
            retry_cnt <= '0;
            tmr <= '0;
            tx_tog <= 1'b0;
            rx_tog <= 1'b0;
            ans_new <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (read_ack) read_valid <= 1'b0;
            case (state)
                IDLE, READ_PEND: begin
                    if (rx_take) begin
                        ans_new <= rx_fresh;
                        state <= ANS_PREP;
                    end else if (state == READ_PEND) begin
                        if (!read_valid) state <= IDLE;
                    end else if (send_req) begin
                        retry_cnt <= '0;
                        state <= SEND_PREP;
                    end
                end
                SEND_PREP: begin
                    tx_start <= 1'b1;
                    state <= SEND;
                end
                SEND: begin
                    tmr <= '0;
                    if (tx_done) state <= ANS_WAIT;
                end
                ANS_WAIT: begin
                    tmr <= tmr + 1'b1;
                    if (rx_done && rx_btype == BAG_ACK) begin
                        send_fail <= 1'b0;
                        if (tx_data) tx_tog <= ~tx_tog;
                        state <= SEND_DONE;
                    end else if ((rx_done && rx_btype == BAG_NAK) || timeout) begin
                        if (retry_cnt == RETRY_W'(RETRY_MAX)) begin
                            send_fail <= 1'b1;     // Retries used up
                            state <= SEND_DONE;
                        end else begin
                            retry_cnt <= retry_cnt + 1'b1;
                            state <= SEND_PREP;
                        end
                    end
                end
                SEND_DONE: begin
                    if (!send_req) state <= IDLE;
                end
                ANS_PREP: begin
                    tx_start <= 1'b1;
                    state <= ANS_SEND;
                end
                default: begin
                    if (tx_done) begin
                        if (ans_new) begin
                            read_valid <= 1'b1;
                            if (read_btype == BAG_DATA0 || read_btype == BAG_DATA1) begin
                                rx_tog <= ~rx_tog;
                            end
                            state <= READ_PEND;
                        end else begin
                            state <= read_valid ? READ_PEND : IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Frame fields stay put until the builder reports tx_done
    always_ff @(posedge clk) begin
        if (rx_take) begin
            tx_btype <= rx_nak ? BAG_NAK : BAG_ACK;
            tx_base <= '0;
            tx_len <= '0;
            if (rx_fresh) begin
                read_btype <= rx_btype;
                read_len <= rx_len;
            end
        end else if (state == SEND_PREP) begin
            tx_btype <= (send_btype == BAG_DATA0 && tx_tog) ? BAG_DATA1 : send_btype;
            tx_base <= send_base;
            tx_len <= send_len;
        end
    end

endmodule

//--- source/link_pkg.sv
package link_pkg;

    // --------------------------------------------------
    // Packet types, upper nibble of the header byte
    // --------------------------------------------------
    localparam int BTYPE_W = 4;

    localparam logic [BTYPE_W-1:0] BAG_ACK    = 4'b0001;
    localparam logic [BTYPE_W-1:0] BAG_NAK    = 4'b0010;
    localparam logic [BTYPE_W-1:0] BAG_DPARAM = 4'b0110;
    localparam logic [BTYPE_W-1:0] BAG_DATA0  = 4'b1101;
    localparam logic [BTYPE_W-1:0] BAG_DATA1  = 4'b1110;
    localparam logic [BTYPE_W-1:0] BAG_ERROR  = 4'b1111;  // Parser verdict only

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int LEN_W  = 8;   // Payload length and buffer address
    localparam int BYTE_W = 8;

    // --------------------------------------------------
    // Retransmission
    // --------------------------------------------------
    localparam int RETRY_MAX = 3;
    localparam int RETRY_W   = $clog2(RETRY_MAX + 1);

    // Answer wait after tx_done, in cycles
    localparam logic [31:0] ACK_TIMEOUT = 32'd600;
    localparam int TMR_W = 10;

endpackage

//--- source/link_top.sv
`timescale 1ns/1ps

module link_top import link_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    // Host buffer access
    input  logic               host_wr_en,
    input  logic [LEN_W-1:0]   host_wr_addr,
    input  logic [BYTE_W-1:0]  host_wr_data,
    input  logic [LEN_W-1:0]   host_rd_addr,
    output logic [BYTE_W-1:0]  host_rd_data,
    // Host send
    input  logic               send_req,
    input  logic [BTYPE_W-1:0] send_btype,
    input  logic [LEN_W-1:0]   send_len,
    input  logic [LEN_W-1:0]   send_base,
    output logic               send_done,
    output logic               send_fail,
    // Host receive
    output logic               read_valid,
    output logic [BTYPE_W-1:0] read_btype,
    output logic [LEN_W-1:0]   read_len,
    input  logic               read_ack,
    // Line
    output logic [BYTE_W-1:0]  line_tx_data,
    output logic               line_tx_valid,
    input  logic [BYTE_W-1:0]  line_rx_data,
    input  logic               line_rx_valid
);

    logic               tx_start;
    logic [BTYPE_W-1:0] tx_btype;
    logic [LEN_W-1:0]   tx_base;
    logic [LEN_W-1:0]   tx_len;
    logic               tx_done;
    logic               rx_done;
    logic [BTYPE_W-1:0] rx_btype;
    logic [LEN_W-1:0]   rx_len;
    logic [LEN_W-1:0]   tx_rd_addr;
    logic [BYTE_W-1:0]  tx_rd_data;
    logic               rx_wr_en;
    logic [LEN_W-1:0]   rx_wr_addr;
    logic [BYTE_W-1:0]  rx_wr_data;
    logic               rx_buf_we;

    // Pending frame in the buffer is protected until read_ack
    assign rx_buf_we = rx_wr_en && !read_valid;

    link_ctrl i_link_ctrl (
        .clk        (clk),
        .rst        (rst),
        .send_req   (send_req),
        .send_btype (send_btype),
        .send_len   (send_len),
        .send_base  (send_base),
        .send_done  (send_done),
        .send_fail  (send_fail),
        .read_ack   (read_ack),
        .read_valid (read_valid),
        .read_btype (read_btype),
        .read_len   (read_len),
        .tx_start   (tx_start),
        .tx_btype   (tx_btype),
        .tx_base    (tx_base),
        .tx_len     (tx_len),
        .tx_done    (tx_done),
        .rx_done    (rx_done),
        .rx_btype   (rx_btype),
        .rx_len     (rx_len)
    );

    frame_tx i_frame_tx (
        .clk           (clk),
        .rst           (rst),
        .tx_start      (tx_start),
        .tx_btype      (tx_btype),
        .tx_base       (tx_base),
        .tx_len        (tx_len),
        .buf_rd_addr   (tx_rd_addr),
        .buf_rd_data   (tx_rd_data),
        .line_tx_data  (line_tx_data),
        .line_tx_valid (line_tx_valid),
        .tx_done       (tx_done)
    );

    frame_rx i_frame_rx (
        .clk           (clk),
        .rst           (rst),
        .line_rx_data  (line_rx_data),
        .line_rx_valid (line_rx_valid),
        .buf_wr_en     (rx_wr_en),
        .buf_wr_addr   (rx_wr_addr),
        .buf_wr_data   (rx_wr_data),
        .rx_done       (rx_done),
        .rx_btype      (rx_btype),
        .rx_len        (rx_len)
    );

    // --------------------------------------------------
    // Buffers
    // --------------------------------------------------
    byte_ram tx_buf (
        .clk     (clk),
        .wr_en   (host_wr_en),
        .wr_addr (host_wr_addr),
        .wr_data (host_wr_data),
        .rd_addr (tx_rd_addr),
        .rd_data (tx_rd_data)
    );

    byte_ram rx_buf (
        .clk     (clk),
        .wr_en   (rx_buf_we),
        .wr_addr (rx_wr_addr),
        .wr_data (rx_wr_data),
        .rd_addr (host_rd_addr),
        .rd_data (host_rd_data)
    );

endmodule

//--- testbench/link_tb.sv
`timescale 1ns/1ps

module link_tb import link_pkg::*; ();

    localparam int FRAME_WAIT = int'(ACK_TIMEOUT) + 50;
    // Sends and receive exchanges over all tests
    localparam int SEND_COUNT = 9;
    localparam int WATCHDOG_CYCLES =
        SEND_COUNT * (RETRY_MAX + 1) * (int'(ACK_TIMEOUT) + 300) + 1000;

    logic               clk;
    logic               rst;
    logic               host_wr_en;
    logic [LEN_W-1:0]   host_wr_addr;
    logic [BYTE_W-1:0]  host_wr_data;
    logic [LEN_W-1:0]   host_rd_addr;
    logic [BYTE_W-1:0]  host_rd_data;
    logic               send_req;
    logic [BTYPE_W-1:0] send_btype;
    logic [LEN_W-1:0]   send_len;
    logic [LEN_W-1:0]   send_base;
    logic               send_done;
    logic               send_fail;
    logic               read_valid;
    logic [BTYPE_W-1:0] read_btype;
    logic [LEN_W-1:0]   read_len;
    logic               read_ack;
    logic [BYTE_W-1:0]  line_tx_data;
    logic               line_tx_valid;
    logic [BYTE_W-1:0]  line_rx_data;
    logic               line_rx_valid;

    integer            seed;
    int                err_cnt;
    int                quiet_err_cnt;
    int                test_cnt;
    int                fail_cnt;
    int                test_base;
    string             cur_test;
    logic              read_quiet;   // No report allowed while set
    logic              exp_tog;      // Sender toggle the peer expects next
    logic [BYTE_W-1:0] tx_pay [0:255];
    logic [BYTE_W-1:0] rx_pay [0:255];
    logic [BYTE_W-1:0] exp_frame [$];

    tb_clock i_tb_clock (.clk(clk));

    link_top i_link_top (.*);

    quiet_read: assert property (@(posedge clk) disable iff (rst) !(read_quiet && read_valid))
        else begin
            quiet_err_cnt++;
            $display("ERROR %s: read_valid rose for a frame that must not be reported", cur_test);
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TIMEOUT: run exceeded %0d cycles during test %s", WATCHDOG_CYCLES, cur_test);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Host and peer helpers
    // --------------------------------------------------
    task automatic load_tx_buf(input int base, input int len);
        logic [LEN_W-1:0] a;
        int i;
        for (i = 0; i < len; i++) begin
            a = LEN_W'(base + i);
            tx_pay[a] = BYTE_W'($random(seed));
            @(negedge clk);
            host_wr_en = 1'b1;
            host_wr_addr = a;
            host_wr_data = tx_pay[a];
        end
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    task automatic fill_rx_pay(input int len);
        int i;
        for (i = 0; i < len; i++) rx_pay[LEN_W'(i)] = BYTE_W'($random(seed));
    endtask

    // Reference frame built from the line format with the host's payload copy
    function automatic void build_frame(input logic [BTYPE_W-1:0] btype, input int base,
                                        input int len);
        logic [BYTE_W-1:0] sum;
        logic [LEN_W-1:0]  a;
        int i;
        exp_frame.delete();
        sum = {btype, {(BYTE_W-BTYPE_W){1'b0}}};
        exp_frame.push_back(sum);
        exp_frame.push_back(BYTE_W'(len));
        sum = sum ^ BYTE_W'(len);
        for (i = 0; i < len; i++) begin
            a = LEN_W'(base + i);   // Wraps at the buffer end
            exp_frame.push_back(tx_pay[a]);
            sum = sum ^ tx_pay[a];
        end
        exp_frame.push_back(sum);
    endfunction

    task automatic put_byte(input logic [BYTE_W-1:0] data, input bit gap);
        @(negedge clk);
        line_rx_valid = 1'b1;
        line_rx_data = data;
        if (gap) begin
            @(negedge clk);
            line_rx_valid = 1'b0;
        end
    endtask

    task automatic send_rx_frame(input logic [BTYPE_W-1:0] btype, input int len,
                                 input bit corrupt, input bit gap);
        logic [BYTE_W-1:0] sum;
        logic [LEN_W-1:0]  a;
        int i;
        sum = {btype, {(BYTE_W-BTYPE_W){1'b0}}} ^ BYTE_W'(len);
        put_byte({btype, {(BYTE_W-BTYPE_W){1'b0}}}, gap);
        put_byte(BYTE_W'(len), gap);
        for (i = 0; i < len; i++) begin
            a = LEN_W'(i);
            put_byte(rx_pay[a], gap);
            sum = sum ^ rx_pay[a];
        end
        put_byte(corrupt ? ~sum : sum, gap);
        @(negedge clk);
        line_rx_valid = 1'b0;
    endtask

    task automatic check_line_frame();
        int waited;
        int i;
        waited = 0;
        @(negedge clk);
        while (!line_tx_valid && waited < FRAME_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (line_tx_valid) else begin
            err_cnt++;
            $display("ERROR %s: no frame on the line within %0d cycles", cur_test, FRAME_WAIT);
        end
        if (line_tx_valid) begin
            for (i = 0; i < exp_frame.size(); i++) begin
                assert (line_tx_valid) else begin
                    err_cnt++;
                    $display("ERROR %s: line went idle inside a frame at byte %0d", cur_test, i);
                end
                assert (line_tx_data == exp_frame[i]) else begin
                    err_cnt++;
                    $display("ERROR %s: line byte %0d expected %h actual %h",
                             cur_test, i, exp_frame[i], line_tx_data);
                end
                @(negedge clk);
            end
            assert (!line_tx_valid) else begin
                err_cnt++;
                $display("ERROR %s: frame on the line is longer than expected", cur_test);
            end
        end
    endtask

    task automatic finish_send(input bit fail_exp);
        int waited;
        waited = 0;
        while (!send_done && waited < FRAME_WAIT) begin
            assert (!line_tx_valid) else begin
                err_cnt++;
                $display("ERROR %s: extra frame on the line before send_done", cur_test);
            end
            @(negedge clk);
            waited++;
        end
        assert (send_done) else begin
            err_cnt++;
            $display("ERROR %s: send_done did not rise", cur_test);
        end
        if (send_done) begin
            assert (send_fail == fail_exp) else begin
                err_cnt++;
                $display("ERROR %s: send_fail expected %0b actual %0b",
                         cur_test, fail_exp, send_fail);
            end
        end
        send_req = 1'b0;
        waited = 0;
        @(negedge clk);
        while (send_done && waited < FRAME_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (!send_done) else begin
            err_cnt++;
            $display("ERROR %s: send_done stayed high after send_req fell", cur_test);
        end
    endtask

    // Peer either NAKs nak_cnt times and then ACKs or stays silent
    task automatic data_send(input int base, input int len, input int nak_cnt, input bit silent);
        int n;
        int frames;
        frames = silent ? RETRY_MAX + 1 : nak_cnt + 1;
        @(negedge clk);
        send_btype = BAG_DATA0;
        send_base = LEN_W'(base);
        send_len = LEN_W'(len);
        send_req = 1'b1;
        build_frame(exp_tog ? BAG_DATA1 : BAG_DATA0, base, len);
        for (n = 0; n < frames; n++) begin
            check_line_frame();
            if (!silent) send_rx_frame((n < nak_cnt) ? BAG_NAK : BAG_ACK, 0, 1'b0, 1'b0);
        end
        finish_send(silent);
        if (!silent) exp_tog = ~exp_tog;   // Only a delivered frame advances it
    endtask

    task automatic check_read(input logic [BTYPE_W-1:0] btype_exp, input int len_exp);
        logic [LEN_W-1:0] a;
        int waited;
        int i;
        waited = 0;
        while (!read_valid && waited < FRAME_WAIT) begin
            @(negedge clk);
            waited++;
        end
        assert (read_valid) else begin
            err_cnt++;
            $display("ERROR %s: read_valid did not rise for a new frame", cur_test);
        end
        assert (read_btype == btype_exp) else begin
            err_cnt++;
            $display("ERROR %s: read_btype expected %h actual %h", cur_test, btype_exp, read_btype);
        end
        assert (read_len == LEN_W'(len_exp)) else begin
            err_cnt++;
            $display("ERROR %s: read_len expected %0d actual %0d", cur_test, len_exp, read_len);
        end
        for (i = 0; i < len_exp; i++) begin
            a = LEN_W'(i);
            @(negedge clk);
            host_rd_addr = a;
            @(negedge clk);
            assert (host_rd_data == rx_pay[a]) else begin
                err_cnt++;
                $display("ERROR %s: read byte %0d expected %h actual %h",
                         cur_test, i, rx_pay[a], host_rd_data);
            end
        end
        @(negedge clk);
        read_ack = 1'b1;
        @(negedge clk);
        read_ack = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_base = err_cnt + quiet_err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt + quiet_err_cnt == test_base) begin
            $display("PASS %s", cur_test);
        end else begin
            fail_cnt++;
            $display("FAIL %s with %0d errors", cur_test, err_cnt + quiet_err_cnt - test_base);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        seed = 32'h3ea42069;
        err_cnt = 0;
        quiet_err_cnt = 0;
        test_cnt = 0;
        fail_cnt = 0;
        test_base = 0;
        cur_test = "reset";
        read_quiet = 1'b0;
        exp_tog = 1'b0;
        rst = 1'b1;
        host_wr_en = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_addr = '0;
        send_req = 1'b0;
        send_btype = BAG_DATA0;
        send_len = '0;
        send_base = '0;
        read_ack = 1'b0;
        line_rx_data = '0;
        line_rx_valid = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        begin_test("send_with_ack");
        load_tx_buf(0, 40);
        data_send(0, 40, 0, 1'b0);
        load_tx_buf(100, 17);
        data_send(100, 17, 0, 1'b0);   // Goes out as DATA1
        end_test();

        begin_test("nak_retransmit");
        load_tx_buf(250, 12);
        data_send(250, 12, 2, 1'b0);
        end_test();

        begin_test("silent_peer");
        load_tx_buf(30, 9);
        data_send(30, 9, 0, 1'b1);
        data_send(30, 9, 0, 1'b0);     // Same type as the failed send
        end_test();

        begin_test("good_receive");
        fill_rx_pay(33);
        send_rx_frame(BAG_DATA0, 33, 1'b0, 1'b0);
        build_frame(BAG_ACK, 0, 0);
        check_line_frame();
        check_read(BAG_DATA0, 33);
        end_test();

        begin_test("bad_and_duplicate");
        read_quiet = 1'b1;
        send_rx_frame(BAG_DATA1, 33, 1'b1, 1'b1);   // Wrong checksum and spaced bytes
        build_frame(BAG_NAK, 0, 0);
        check_line_frame();
        repeat (10) @(negedge clk);
        send_rx_frame(BAG_DATA0, 33, 1'b0, 1'b0);   // Repeat of the accepted DATA0
        build_frame(BAG_ACK, 0, 0);
        check_line_frame();
        repeat (10) @(negedge clk);
        read_quiet = 1'b0;
        fill_rx_pay(48);
        send_rx_frame(BAG_DATA1, 48, 1'b0, 1'b0);
        build_frame(BAG_ACK, 0, 0);
        check_line_frame();
        check_read(BAG_DATA1, 48);
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d",
                 test_cnt, fail_cnt, err_cnt + quiet_err_cnt);
        if (err_cnt + quiet_err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD = 5   // ns, gives a 10 ns clock
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule
